//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert -Ihdl
TOP       ?= machine_csr_tb
FILELIST  ?= machine_csr_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- hdl/clint_timer.sv
`timescale 1ns/1ps
`include "csr_cfg.svh"

module clint_timer (
    input  logic        clk,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [3:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic        mtip
);

    logic [63:0] mtime;
    logic [63:0] mtimecmp;
    logic        access;
    logic        wr_en;
    logic        unmapped;
    logic        mtime_wr;

    assign access   = psel && penable;
    assign wr_en    = access && pwrite;
    assign unmapped = (paddr[1:0] != 2'b00);
    // mtime is read-only from the bus
    assign mtime_wr = (paddr == `CLINT_MTIME_LO) || (paddr == `CLINT_MTIME_HI);

    // zero wait states
    assign pready  = access;
    assign pslverr = access && (unmapped || (pwrite && mtime_wr));

    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            case (paddr)
                `CLINT_MTIMECMP_LO: prdata = mtimecmp[31:0];
                `CLINT_MTIMECMP_HI: prdata = mtimecmp[63:32];
                `CLINT_MTIME_LO:    prdata = mtime[31:0];
                `CLINT_MTIME_HI:    prdata = mtime[63:32];
                default:            prdata = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mtime    <= '0;
            mtimecmp <= '1;
            mtip     <= 1'b0;
        end else begin
            mtime <= mtime + 1'b1;
            if (wr_en && paddr == `CLINT_MTIMECMP_LO) begin
                mtimecmp[31:0] <= pwdata;
            end
            if (wr_en && paddr == `CLINT_MTIMECMP_HI) begin
                mtimecmp[63:32] <= pwdata;
            end
            // one cycle behind the compare
            mtip <= (mtime >= mtimecmp);
        end
    end

endmodule

//--- hdl/csr_access.sv
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_access (
    input  logic                    inst_valid,
    input  csr_pkg::csr_op_e        csr_op,
    input  logic [`CSR_ADDR_W-1:0]  csr_addr,
    input  logic                    csr_use_imm,
    input  logic [`CSR_XLEN-1:0]    rs1_data,
    input  logic [`CSR_XLEN-1:0]    imm_csr,
    input  logic [`CSR_XLEN-1:0]    mstatus,
    input  logic [`CSR_XLEN-1:0]    mtvec,
    input  logic [`CSR_XLEN-1:0]    mepc,
    input  logic [`CSR_XLEN-1:0]    mcause,
    input  logic [`CSR_XLEN-1:0]    mip,
    input  logic [`CSR_XLEN-1:0]    mie,
    input  logic [`CSR_XLEN-1:0]    mscratch,
    input  logic [`CSR_XLEN-1:0]    mcycle,
    input  logic [`CSR_XLEN-1:0]    minstret,
    output csr_pkg::csr_sel_t       csr_sel,
    output logic [`CSR_XLEN-1:0]    wdata,
    output logic [`CSR_XLEN-1:0]    csr_read,
    output logic                    csr_illegal
);

    csr_pkg::csr_sel_t           hit_sel;
    logic                        hit;
    logic                        op_en;
    logic [`CSR_XLEN-1:0]        src;

    // address decode and old-value mux
    always_comb begin
        hit_sel  = '0;
        hit      = 1'b1;
        csr_read = '0;
        case (csr_addr)
            `CSR_MSTATUS:   begin hit_sel.mstatus  = 1'b1; csr_read = mstatus;  end
            `CSR_MTVEC:     begin hit_sel.mtvec    = 1'b1; csr_read = mtvec;    end
            `CSR_MEPC:      begin hit_sel.mepc     = 1'b1; csr_read = mepc;     end
            `CSR_MCAUSE:    begin hit_sel.mcause   = 1'b1; csr_read = mcause;   end
            `CSR_MIP:       begin hit_sel.mip      = 1'b1; csr_read = mip;      end
            `CSR_MIE:       begin hit_sel.mie      = 1'b1; csr_read = mie;      end
            `CSR_MSCRATCH:  begin hit_sel.mscratch = 1'b1; csr_read = mscratch; end
            `CSR_MCYCLE:    begin hit_sel.mcycle   = 1'b1; csr_read = mcycle;   end
            `CSR_MINSTRET:  begin hit_sel.minstret = 1'b1; csr_read = minstret; end
            // read-only ID space, writes dropped
            `CSR_MISA:      csr_read = `MISA_VALUE;
            `CSR_MARCHID:   csr_read = `MARCHID_VALUE;
            `CSR_MVENDORID: csr_read = '0;
            `CSR_MIMPID:    csr_read = '0;
            `CSR_MHARTID:   csr_read = '0;
            default:        hit = 1'b0;
        endcase
    end

    assign op_en = inst_valid && (csr_op != csr_pkg::CSR_OP_NONE);

    assign csr_sel     = op_en ? hit_sel : '0;
    assign csr_illegal = op_en && !hit;

    assign src = csr_use_imm ? imm_csr : rs1_data;

    // read-modify-write result
    always_comb begin
        case (csr_op)
            csr_pkg::CSR_OP_RW:    wdata = src;
            csr_pkg::CSR_OP_SET:   wdata = csr_read | src;
            csr_pkg::CSR_OP_CLEAR: wdata = csr_read & ~src;
            default:               wdata = csr_read;
        endcase
    end

endmodule

//--- hdl/csr_cfg.svh
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

`define CSR_XLEN            64
`define CSR_ADDR_W          12

// machine CSR addresses
`define CSR_MSTATUS         12'h300
`define CSR_MISA            12'h301
`define CSR_MIE             12'h304
`define CSR_MTVEC           12'h305
`define CSR_MSCRATCH        12'h340
`define CSR_MEPC            12'h341
`define CSR_MCAUSE          12'h342
`define CSR_MIP             12'h344
`define CSR_MCYCLE          12'hB00
`define CSR_MINSTRET        12'hB02
`define CSR_MVENDORID       12'hF11
`define CSR_MARCHID         12'hF12
`define CSR_MIMPID          12'hF13
`define CSR_MHARTID         12'hF14

`define CAUSE_ECALL         64'd11
`define CAUSE_EBREAK        64'd3
`define CAUSE_MTIMER        64'h8000_0000_0000_0007

// MXL=2, I extension only
`define MISA_VALUE          64'h8000_0000_0000_0100
`define MARCHID_VALUE       64'd1

// MTIP / MTIE position in mip and mie
`define CSR_MTI_BIT         7

`define CLINT_MTIMECMP_LO   4'h0
`define CLINT_MTIMECMP_HI   4'h4
`define CLINT_MTIME_LO      4'h8
`define CLINT_MTIME_HI      4'hC

`endif

//--- hdl/csr_pkg.sv
`include "csr_cfg.svh"

package csr_pkg;

    // encoding taken from the core's csr_ctrl field
    typedef enum logic [1:0] {
        CSR_OP_NONE  = 2'b00,
        CSR_OP_RW    = 2'b01,
        CSR_OP_SET   = 2'b10,
        CSR_OP_CLEAR = 2'b11
    } csr_op_e;

    typedef struct packed {
        logic                    sd;
        logic [`CSR_XLEN-19:0]   rsvd_62_17;
        logic [1:0]              xs;
        logic [1:0]              fs;
        logic [1:0]              mpp;
        logic [2:0]              rsvd_10_8;
        logic                    mpie;
        logic [2:0]              rsvd_6_4;
        logic                    mie;
        logic [2:0]              rsvd_2_0;
    } mstatus_fields_t;

    typedef union packed {
        logic [`CSR_XLEN-1:0]    raw;
        mstatus_fields_t         f;
    } mstatus_u;

    // one bit per writable CSR
    typedef struct packed {
        logic mstatus;
        logic mtvec;
        logic mepc;
        logic mcause;
        logic mip;
        logic mie;
        logic mscratch;
        logic mcycle;
        logic minstret;
    } csr_sel_t;

endpackage

//--- hdl/csr_regfile.sv
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_regfile (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    inst_valid,
    input  csr_pkg::csr_sel_t       csr_sel,
    input  logic [`CSR_XLEN-1:0]    wdata,
    input  logic [`CSR_XLEN-1:0]    inst_addr,
    input  logic                    inst_ecall,
    input  logic                    inst_ebreak,
    input  logic                    inst_trap,
    input  logic                    inst_mret,
    input  logic                    mtip,
    output logic [`CSR_XLEN-1:0]    mstatus,
    output logic [`CSR_XLEN-1:0]    mtvec,
    output logic [`CSR_XLEN-1:0]    mepc,
    output logic [`CSR_XLEN-1:0]    mcause,
    output logic [`CSR_XLEN-1:0]    mip,
    output logic [`CSR_XLEN-1:0]    mie,
    output logic [`CSR_XLEN-1:0]    mscratch,
    output logic [`CSR_XLEN-1:0]    mcycle,
    output logic [`CSR_XLEN-1:0]    minstret,
    output logic [`CSR_XLEN-1:0]    trap_pc,
    output logic                    irq
);

    csr_pkg::mstatus_u           mstatus_q;
    csr_pkg::mstatus_u           mstatus_wr;
    logic                        trap_en;
    logic                        mret_en;
    logic [`CSR_XLEN-1:0]        trap_cause;

    assign trap_en = inst_valid && inst_trap;
    assign mret_en = inst_valid && inst_mret;

    // ecall wins over ebreak, anything else is the timer
    assign trap_cause = inst_ecall  ? `CAUSE_ECALL  :
                        inst_ebreak ? `CAUSE_EBREAK :
                        `CAUSE_MTIMER;

    // sd summarizes dirty fs / xs
    always_comb begin
        mstatus_wr.raw  = wdata;
        mstatus_wr.f.sd = (mstatus_wr.f.fs == 2'b11) || (mstatus_wr.f.xs == 2'b11);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus_q.raw <= '0;
        end else if (csr_sel.mstatus) begin
            mstatus_q <= mstatus_wr;
        end else if (trap_en) begin
            mstatus_q.f.mpie <= mstatus_q.f.mie;
            mstatus_q.f.mie  <= 1'b0;
            mstatus_q.f.mpp  <= 2'b11;
        end else if (mret_en) begin
            mstatus_q.f.mie  <= mstatus_q.f.mpie;
            mstatus_q.f.mpie <= 1'b1;
            mstatus_q.f.mpp  <= 2'b00;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mtvec    <= '0;
            mscratch <= '0;
            mie      <= '0;
        end else begin
            // direct mode only
            if (csr_sel.mtvec) begin
                mtvec <= {wdata[`CSR_XLEN-1:2], 2'b00};
            end
            if (csr_sel.mscratch) begin
                mscratch <= wdata;
            end
            if (csr_sel.mie) begin
                mie <= '0;
                mie[`CSR_MTI_BIT] <= wdata[`CSR_MTI_BIT];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mepc   <= '0;
            mcause <= '0;
        end else begin
            if (csr_sel.mepc) begin
                mepc <= wdata;
            end else if (trap_en) begin
                mepc <= inst_addr;
            end
            if (csr_sel.mcause) begin
                mcause <= wdata;
            end else if (trap_en) begin
                mcause <= trap_cause;
            end
        end
    end

    // MTIP tracks the timer unless software writes mip
    always_ff @(posedge clk) begin
        if (rst) begin
            mip <= '0;
        end else if (csr_sel.mip) begin
            mip <= '0;
            mip[`CSR_MTI_BIT] <= wdata[`CSR_MTI_BIT];
        end else begin
            mip[`CSR_MTI_BIT] <= mtip;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mcycle   <= '0;
            minstret <= '0;
        end else begin
            if (csr_sel.mcycle) begin
                mcycle <= wdata;
            end else begin
                mcycle <= mcycle + 1'b1;
            end
            if (csr_sel.minstret) begin
                minstret <= wdata;
            end else if (inst_valid) begin
                minstret <= minstret + 1'b1;
            end
        end
    end

    assign mstatus = mstatus_q.raw;

    assign trap_pc = inst_trap ? mtvec : mepc;
    assign irq     = mstatus_q.f.mie && mie[`CSR_MTI_BIT] && mip[`CSR_MTI_BIT];

endmodule

//--- hdl/machine_csr_top.sv
`timescale 1ns/1ps
`include "csr_cfg.svh"

module machine_csr_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    inst_valid,
    input  csr_pkg::csr_op_e        csr_op,
    input  logic [`CSR_ADDR_W-1:0]  csr_addr,
    input  logic                    csr_use_imm,
    input  logic [`CSR_XLEN-1:0]    rs1_data,
    input  logic [`CSR_XLEN-1:0]    imm_csr,
    input  logic [`CSR_XLEN-1:0]    inst_addr,
    input  logic                    inst_ecall,
    input  logic                    inst_ebreak,
    input  logic                    inst_trap,
    input  logic                    inst_mret,
    output logic [`CSR_XLEN-1:0]    csr_read,
    output logic                    csr_illegal,
    output logic [`CSR_XLEN-1:0]    trap_pc,
    output logic                    irq,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [3:0]              paddr,
    input  logic [31:0]             pwdata,
    output logic [31:0]             prdata,
    output logic                    pready,
    output logic                    pslverr
);

    csr_pkg::csr_sel_t       csr_sel;
    logic [`CSR_XLEN-1:0]    wdata;
    logic [`CSR_XLEN-1:0]    mstatus;
    logic [`CSR_XLEN-1:0]    mtvec;
    logic [`CSR_XLEN-1:0]    mepc;
    logic [`CSR_XLEN-1:0]    mcause;
    logic [`CSR_XLEN-1:0]    mip;
    logic [`CSR_XLEN-1:0]    mie;
    logic [`CSR_XLEN-1:0]    mscratch;
    logic [`CSR_XLEN-1:0]    mcycle;
    logic [`CSR_XLEN-1:0]    minstret;
    logic                    mtip;

    csr_access access_i (
        .inst_valid  (inst_valid),
        .csr_op      (csr_op),
        .csr_addr    (csr_addr),
        .csr_use_imm (csr_use_imm),
        .rs1_data    (rs1_data),
        .imm_csr     (imm_csr),
        .mstatus     (mstatus),
        .mtvec       (mtvec),
        .mepc        (mepc),
        .mcause      (mcause),
        .mip         (mip),
        .mie         (mie),
        .mscratch    (mscratch),
        .mcycle      (mcycle),
        .minstret    (minstret),
        .csr_sel     (csr_sel),
        .wdata       (wdata),
        .csr_read    (csr_read),
        .csr_illegal (csr_illegal)
    );

    csr_regfile regfile_i (
        .clk         (clk),
        .rst         (rst),
        .inst_valid  (inst_valid),
        .csr_sel     (csr_sel),
        .wdata       (wdata),
        .inst_addr   (inst_addr),
        .inst_ecall  (inst_ecall),
        .inst_ebreak (inst_ebreak),
        .inst_trap   (inst_trap),
        .inst_mret   (inst_mret),
        .mtip        (mtip),
        .mstatus     (mstatus),
        .mtvec       (mtvec),
        .mepc        (mepc),
        .mcause      (mcause),
        .mip         (mip),
        .mie         (mie),
        .mscratch    (mscratch),
        .mcycle      (mcycle),
        .minstret    (minstret),
        .trap_pc     (trap_pc),
        .irq         (irq)
    );

    // machine timer on the APB side
    clint_timer clint_i (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .mtip    (mtip)
    );

endmodule

//--- machine_csr_top.f
+incdir+hdl
hdl/csr_pkg.sv
hdl/csr_access.sv
hdl/csr_regfile.sv
hdl/clint_timer.sv
hdl/machine_csr_top.sv
verification/machine_csr_props.sv
verification/machine_csr_tb.sv

//--- verification/machine_csr_props.sv
`timescale 1ns/1ps

module machine_csr_props (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pready,
    input  logic                 inst_valid,
    input  logic                 inst_trap,
    input  logic                 irq,
    input  logic [63:0]          mstatus,
    input  logic                 csr_illegal,
    input  csr_pkg::csr_sel_t    csr_sel
);

    // zero wait state slave
    pready_in_access: assert property (
        @(posedge clk) disable iff (rst) (psel && penable) |-> pready
    ) else $error("pready low during APB access phase");

    // trap entry clears mie, so irq stays low right after it
    trap_masks_irq: assert property (
        @(posedge clk) disable iff (rst)
        (inst_valid && inst_trap && !csr_sel.mstatus) |=> (!mstatus[3] && !irq)
    ) else $error("irq or mstatus.mie high right after trap entry");

    illegal_no_select: assert property (
        @(posedge clk) disable iff (rst) csr_illegal |-> (csr_sel == '0)
    ) else $error("csr_illegal with a select bit set");

endmodule

bind machine_csr_top machine_csr_props props_i (
    .clk         (clk),
    .rst         (rst),
    .psel        (psel),
    .penable     (penable),
    .pready      (pready),
    .inst_valid  (inst_valid),
    .inst_trap   (inst_trap),
    .irq         (irq),
    .mstatus     (mstatus),
    .csr_illegal (csr_illegal),
    .csr_sel     (csr_sel)
);

//--- verification/machine_csr_tb.sv
`timescale 1ns/1ps
`include "csr_cfg.svh"

module machine_csr_tb;

    typedef struct {
        csr_pkg::csr_op_e  op;
        logic [11:0]       addr;
        logic              use_imm;
        logic [63:0]       operand;
        logic              ecall;
        logic              ebreak;
        logic              trap;
        logic              mret;
        logic [63:0]       iaddr;
    } step_t;

    logic clk;
    logic rst;
    logic inst_valid;
    csr_pkg::csr_op_e csr_op;
    logic [11:0] csr_addr;
    logic csr_use_imm;
    logic [63:0] rs1_data;
    logic [63:0] imm_csr;
    logic [63:0] inst_addr;
    logic inst_ecall;
    logic inst_ebreak;
    logic inst_trap;
    logic inst_mret;
    logic [63:0] csr_read;
    logic csr_illegal;
    logic [63:0] trap_pc;
    logic irq;
    logic psel;
    logic penable;
    logic pwrite;
    logic [3:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic pready;
    logic pslverr;

    step_t tbl[$];
    logic [15:0] lfsr = 16'd13045;
    int errs = 0;
    int checks = 0;

    // reference state
    csr_pkg::mstatus_u m_status;
    logic [63:0] m_mtvec, m_mepc, m_mcause, m_mip, m_mie, m_mscratch;

    machine_csr_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #500000;
        $display("simulation did not finish in time");
        $display("RESULT: FAIL");
        $finish;
    end

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return v;
    endfunction

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("ERR %s got %h exp %h", name, got, exp);
            errs++;
        end
    endtask

    task automatic add_step(input csr_pkg::csr_op_e op, input logic [11:0] addr,
                            input logic use_imm, input logic [63:0] operand,
                            input logic ecall, input logic ebreak, input logic trap,
                            input logic mret, input logic [63:0] iaddr);
        step_t s;
        s.op = op;
        s.addr = addr;
        s.use_imm = use_imm;
        s.operand = operand;
        s.ecall = ecall;
        s.ebreak = ebreak;
        s.trap = trap;
        s.mret = mret;
        s.iaddr = iaddr;
        tbl.push_back(s);
    endtask

    task automatic drive_inst(input logic valid, input step_t s);
        inst_valid = valid;
        csr_op = s.op;
        csr_addr = s.addr;
        csr_use_imm = s.use_imm;
        // the unused source carries the inverse to catch a wrong mux
        rs1_data = s.use_imm ? ~s.operand : s.operand;
        imm_csr = s.use_imm ? s.operand : ~s.operand;
        inst_addr = s.iaddr;
        inst_ecall = s.ecall;
        inst_ebreak = s.ebreak;
        inst_trap = s.trap;
        inst_mret = s.mret;
    endtask

    function automatic step_t csr_step(input csr_pkg::csr_op_e op, input logic [11:0] addr,
                                       input logic [63:0] val);
        step_t s;
        s = '{op, addr, 1'b0, val, 1'b0, 1'b0, 1'b0, 1'b0, 64'h0};
        return s;
    endfunction

    function automatic logic model_mapped(input logic [11:0] a);
        case (a)
            `CSR_MSTATUS, `CSR_MTVEC, `CSR_MEPC, `CSR_MCAUSE, `CSR_MIP, `CSR_MIE,
            `CSR_MSCRATCH, `CSR_MCYCLE, `CSR_MINSTRET, `CSR_MISA, `CSR_MARCHID,
            `CSR_MVENDORID, `CSR_MIMPID, `CSR_MHARTID: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [63:0] model_read(input logic [11:0] a);
        case (a)
            `CSR_MSTATUS:  return m_status.raw;
            `CSR_MTVEC:    return m_mtvec;
            `CSR_MEPC:     return m_mepc;
            `CSR_MCAUSE:   return m_mcause;
            `CSR_MIP:      return m_mip;
            `CSR_MIE:      return m_mie;
            `CSR_MSCRATCH: return m_mscratch;
            `CSR_MISA:     return `MISA_VALUE;
            `CSR_MARCHID:  return `MARCHID_VALUE;
            default:       return 64'h0;
        endcase
    endfunction

    // one clock edge of the reference model, timer idle
    task automatic model_update(input step_t s);
        logic [63:0] old;
        logic [63:0] nv;
        logic wr;
        csr_pkg::mstatus_u tmp;
        old = model_read(s.addr);
        wr = (s.op != csr_pkg::CSR_OP_NONE);
        case (s.op)
            csr_pkg::CSR_OP_RW:  nv = s.operand;
            csr_pkg::CSR_OP_SET: nv = old | s.operand;
            default:             nv = old & ~s.operand;
        endcase
        if (wr && s.addr == `CSR_MSTATUS) begin
            tmp.raw = nv;
            tmp.f.sd = (tmp.f.fs == 2'b11) || (tmp.f.xs == 2'b11);
            m_status = tmp;
        end else if (s.trap) begin
            m_status.f.mpie = m_status.f.mie;
            m_status.f.mie = 1'b0;
            m_status.f.mpp = 2'b11;
        end else if (s.mret) begin
            m_status.f.mie = m_status.f.mpie;
            m_status.f.mpie = 1'b1;
            m_status.f.mpp = 2'b00;
        end
        if (wr && s.addr == `CSR_MEPC) m_mepc = nv;
        else if (s.trap) m_mepc = s.iaddr;
        if (wr && s.addr == `CSR_MCAUSE) m_mcause = nv;
        else if (s.trap) m_mcause = s.ecall ? `CAUSE_ECALL :
                                    s.ebreak ? `CAUSE_EBREAK : `CAUSE_MTIMER;
        if (wr && s.addr == `CSR_MTVEC) m_mtvec = nv & ~64'h3;
        if (wr && s.addr == `CSR_MIE) m_mie = nv & 64'h80;
        if (wr && s.addr == `CSR_MSCRATCH) m_mscratch = nv;
        m_mip = (wr && s.addr == `CSR_MIP) ? (nv & 64'h80) : 64'h0;
    endtask

    task automatic exec(input logic valid, input step_t s, output logic [63:0] rd);
        @(posedge clk);
        #1;
        drive_inst(valid, s);
        #3;
        rd = csr_read;
    endtask

    task automatic apb_xfer(input logic wr, input logic [3:0] a, input logic [31:0] wd,
                            output logic [31:0] rd, output logic err);
        int cnt;
        @(posedge clk);
        #1;
        psel = 1'b1;
        penable = 1'b0;
        pwrite = wr;
        paddr = a;
        pwdata = wd;
        @(posedge clk);
        #1;
        penable = 1'b1;
        #3;
        cnt = 0;
        while (!pready && cnt < 16) begin
            @(posedge clk);
            #4;
            cnt++;
        end
        assert (pready) else begin
            $display("APB transfer timed out waiting for pready");
            errs++;
        end
        rd = prdata;
        err = pslverr;
        @(posedge clk);
        #1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic wait_irq(input logic level);
        int cnt;
        cnt = 0;
        while (irq !== level && cnt < 200) begin
            @(posedge clk);
            #4;
            cnt++;
        end
        assert (irq === level) else begin
            $display("irq did not reach %0d before timeout", level);
            errs++;
        end
    endtask

    initial begin
        logic [63:0] r, rd, c1, c2;
        logic [31:0] t1, t2, prd;
        logic err;
        clk = 1'b0;
        rst = 1'b1;
        inst_valid = 1'b0;
        csr_op = csr_pkg::CSR_OP_NONE;
        csr_addr = '0;
        csr_use_imm = 1'b0;
        rs1_data = '0;
        imm_csr = '0;
        inst_addr = '0;
        inst_ecall = 1'b0;
        inst_ebreak = 1'b0;
        inst_trap = 1'b0;
        inst_mret = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        m_status.raw = '0;
        m_mtvec = '0;
        m_mepc = '0;
        m_mcause = '0;
        m_mip = '0;
        m_mie = '0;
        m_mscratch = '0;

        r = rand_bits(64);
        add_step(csr_pkg::CSR_OP_RW, `CSR_MSCRATCH, 1'b0, r, 0, 0, 0, 0, 0);
        r = rand_bits(5);
        add_step(csr_pkg::CSR_OP_SET, `CSR_MSCRATCH, 1'b1, r, 0, 0, 0, 0, 0);
        r = rand_bits(64);
        add_step(csr_pkg::CSR_OP_CLEAR, `CSR_MSCRATCH, 1'b0, r, 0, 0, 0, 0, 0);
        r = rand_bits(64);
        add_step(csr_pkg::CSR_OP_RW, `CSR_MTVEC, 1'b0, r, 0, 0, 0, 0, 0);
        add_step(csr_pkg::CSR_OP_SET, `CSR_MTVEC, 1'b1, 64'h3, 0, 0, 0, 0, 0);
        add_step(csr_pkg::CSR_OP_RW, `CSR_MIE, 1'b0, '1, 0, 0, 0, 0, 0);
        add_step(csr_pkg::CSR_OP_CLEAR, `CSR_MIE, 1'b0, 64'h80, 0, 0, 0, 0, 0);
        add_step(csr_pkg::CSR_OP_RW, `CSR_MIP, 1'b0, 64'hff, 0, 0, 0, 0, 0);
        add_step(csr_pkg::CSR_OP_SET, `CSR_MIP, 1'b1, 64'h0, 0, 0, 0, 0, 0);
        add_step(csr_pkg::CSR_OP_CLEAR, `CSR_MIP, 1'b1, 64'h80, 0, 0, 0, 0, 0);
        add_step(csr_pkg::CSR_OP_SET, `CSR_MIP, 1'b0, 64'h0, 0, 0, 0, 0, 0);
        r = rand_bits(64);
        add_step(csr_pkg::CSR_OP_RW, `CSR_MISA, 1'b0, r, 0, 0, 0, 0, 0);
        add_step(csr_pkg::CSR_OP_RW, `CSR_MARCHID, 1'b0, r, 0, 0, 0, 0, 0);
        add_step(csr_pkg::CSR_OP_SET, `CSR_MVENDORID, 1'b0, r, 0, 0, 0, 0, 0);
        add_step(csr_pkg::CSR_OP_SET, `CSR_MIMPID, 1'b1, r, 0, 0, 0, 0, 0);
        add_step(csr_pkg::CSR_OP_CLEAR, `CSR_MHARTID, 1'b0, r, 0, 0, 0, 0, 0);
        add_step(csr_pkg::CSR_OP_RW, 12'h7C0, 1'b0, r, 0, 0, 0, 0, 0);
        // ID registers read back unchanged after the writes above
        add_step(csr_pkg::CSR_OP_SET, `CSR_MISA, 1'b1, 64'h0, 0, 0, 0, 0, 0);
        add_step(csr_pkg::CSR_OP_SET, `CSR_MARCHID, 1'b1, 64'h0, 0, 0, 0, 0, 0);
        add_step(csr_pkg::CSR_OP_SET, `CSR_MSTATUS, 1'b0, 64'h6008, 0, 0, 0, 0, 0);
        r = rand_bits(64);
        add_step(csr_pkg::CSR_OP_NONE, `CSR_MSTATUS, 1'b0, 0, 1, 0, 1, 0, r & ~64'h3);
        add_step(csr_pkg::CSR_OP_SET, `CSR_MEPC, 1'b0, 0, 0, 0, 0, 0, 0);
        add_step(csr_pkg::CSR_OP_SET, `CSR_MCAUSE, 1'b0, 0, 0, 0, 0, 0, 0);
        add_step(csr_pkg::CSR_OP_NONE, `CSR_MSTATUS, 1'b0, 0, 0, 0, 0, 1, 0);
        r = rand_bits(64);
        add_step(csr_pkg::CSR_OP_NONE, `CSR_MSTATUS, 1'b0, 0, 0, 1, 1, 0, r & ~64'h3);
        add_step(csr_pkg::CSR_OP_NONE, `CSR_MCAUSE, 1'b0, 0, 0, 0, 0, 1, 0);
        r = rand_bits(64);
        add_step(csr_pkg::CSR_OP_NONE, `CSR_MEPC, 1'b0, 0, 0, 0, 1, 0, r & ~64'h3);
        add_step(csr_pkg::CSR_OP_NONE, `CSR_MCAUSE, 1'b0, 0, 0, 0, 0, 1, 0);
        add_step(csr_pkg::CSR_OP_SET, `CSR_MSTATUS, 1'b1, 0, 0, 0, 0, 0, 0);

        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        #3;
        check_val("irq", irq, 0);
        check_val("pslverr", pslverr, 0);
        check_val("csr_illegal", csr_illegal, 0);

        foreach (tbl[i]) begin
            exec(1'b1, tbl[i], rd);
            check_val("csr_read", rd, model_read(tbl[i].addr));
            check_val("csr_illegal", csr_illegal,
                      tbl[i].op != csr_pkg::CSR_OP_NONE && !model_mapped(tbl[i].addr));
            check_val("trap_pc", trap_pc, tbl[i].trap ? m_mtvec : m_mepc);
            model_update(tbl[i]);
        end

        // counters, read with inst_valid low so nothing is disturbed
        exec(1'b0, csr_step(csr_pkg::CSR_OP_NONE, `CSR_MCYCLE, 0), c1);
        repeat (9) @(posedge clk);
        exec(1'b0, csr_step(csr_pkg::CSR_OP_NONE, `CSR_MCYCLE, 0), c2);
        check_val("mcycle_delta", c2 - c1, 64'd10);
        exec(1'b0, csr_step(csr_pkg::CSR_OP_NONE, `CSR_MINSTRET, 0), c1);
        repeat (5) exec(1'b1, csr_step(csr_pkg::CSR_OP_NONE, 12'h0, 0), rd);
        exec(1'b0, csr_step(csr_pkg::CSR_OP_NONE, `CSR_MINSTRET, 0), c2);
        check_val("minstret_delta", c2 - c1, 64'd5);
        r = rand_bits(64);
        exec(1'b1, csr_step(csr_pkg::CSR_OP_RW, `CSR_MCYCLE, r), rd);
        exec(1'b0, csr_step(csr_pkg::CSR_OP_NONE, `CSR_MCYCLE, 0), c1);
        check_val("mcycle", c1, r);
        exec(1'b1, csr_step(csr_pkg::CSR_OP_RW, `CSR_MINSTRET, ~r), rd);
        exec(1'b0, csr_step(csr_pkg::CSR_OP_NONE, `CSR_MINSTRET, 0), c1);
        check_val("minstret", c1, ~r);

        // timer over APB
        apb_xfer(1'b0, `CLINT_MTIME_LO, 0, t1, err);
        check_val("pslverr", err, 0);
        apb_xfer(1'b0, `CLINT_MTIME_HI, 0, prd, err);
        check_val("mtime_hi", prd, 0);
        apb_xfer(1'b0, `CLINT_MTIME_LO, 0, t2, err);
        check_val("mtime_lo_delta", t2 - t1, 32'd6);
        apb_xfer(1'b1, `CLINT_MTIME_LO, 32'h5, prd, err);
        check_val("pslverr", err, 1);
        apb_xfer(1'b0, 4'h2, 0, prd, err);
        check_val("pslverr", err, 1);
        apb_xfer(1'b0, `CLINT_MTIME_LO, 0, t1, err);
        apb_xfer(1'b1, `CLINT_MTIMECMP_LO, t1 + 32'd40, prd, err);
        check_val("pslverr", err, 0);
        apb_xfer(1'b1, `CLINT_MTIMECMP_HI, 32'h0, prd, err);
        exec(1'b1, csr_step(csr_pkg::CSR_OP_SET, `CSR_MIE, 64'h80), rd);
        exec(1'b1, csr_step(csr_pkg::CSR_OP_RW, `CSR_MSTATUS, 64'h8), rd);
        exec(1'b0, csr_step(csr_pkg::CSR_OP_NONE, `CSR_MIP, 0), rd);
        wait_irq(1'b1);
        check_val("mip", csr_read, 64'h80);
        apb_xfer(1'b1, `CLINT_MTIMECMP_LO, 32'hffff_ffff, prd, err);
        apb_xfer(1'b1, `CLINT_MTIMECMP_HI, 32'hffff_ffff, prd, err);
        wait_irq(1'b0);
        exec(1'b0, csr_step(csr_pkg::CSR_OP_NONE, `CSR_MIP, 0), rd);
        check_val("mip", rd, 64'h0);

        $display("checks %0d errors %0d", checks, errs);
        if (errs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
